// ==== verilog/icache_pkg.sv ====
// Shared widths and types for the 4-way, 16-set instruction cache
// One 128-bit fetch word per line, so the byte offset is 4 bits
`default_nettype none

package icache_pkg;

   parameter int ADDR_W       = 32;
   parameter int DATA_W       = 128;
   parameter int NB_WAYS      = 4;   // Default only, the top level sets it
   parameter int NB_SETS_LOG2 = 4;
   parameter int OFFSET_W     = 4;
   parameter int TAG_W        = 8;

   localparam int NB_SETS = 2 ** NB_SETS_LOG2;
   localparam int SET_LSB = OFFSET_W;                  // Set index at bits 7..4
   localparam int TAG_LSB = OFFSET_W + NB_SETS_LOG2;   // Tag at bits 15..8

   typedef logic [ADDR_W-1:0]       addr_t;
   typedef logic [DATA_W-1:0]       data_t;
   typedef logic [NB_SETS_LOG2-1:0] set_idx_t;
   typedef logic [TAG_W-1:0]        tag_t;
   typedef logic [TAG_W:0]          tag_entry_t;       // Valid bit on top

   typedef enum logic [3:0] {
      DISABLED, BYPASS_REFILL, BYPASS_WAIT_DONE, FLUSH_ALL, FLUSH_SET,
      IDLE, TAG_LOOKUP, WAIT_REFILL_GNT, WAIT_REFILL_DONE,
      STATE_SPARE                                      // Decodes to DISABLED
   } ctrl_state_t;

   function automatic set_idx_t set_of(addr_t addr);
      return addr[SET_LSB +: NB_SETS_LOG2];
   endfunction

   function automatic tag_t tag_of(addr_t addr);
      return addr[TAG_LSB +: TAG_W];
   endfunction

endpackage

`default_nettype wire

// ==== verilog/icache_if.sv ====
// Store buses between the cache controller, way selection and the arrays
// Read data arrives one cycle after rd_req; writes land at the clock edge
`default_nettype none

interface tag_bus_if #(
   parameter int NB_WAYS = icache_pkg::NB_WAYS
);
   import icache_pkg::*;

   logic                        rd_req;
   logic [NB_WAYS-1:0]          wr_req;   // One write enable per way
   set_idx_t                    addr;
   tag_entry_t                  wdata;
   tag_entry_t [NB_WAYS-1:0]    rdata;

   modport ctrl   (output rd_req, output wr_req, output addr, output wdata);
   modport store  (input rd_req, input wr_req, input addr, input wdata, output rdata);
   modport lookup (input rdata);

endinterface

interface data_bus_if #(
   parameter int NB_WAYS = icache_pkg::NB_WAYS
);
   import icache_pkg::*;

   logic                   rd_req;
   logic [NB_WAYS-1:0]     wr_req;
   set_idx_t               addr;
   data_t                  wdata;
   data_t [NB_WAYS-1:0]    rdata;

   // Controller picks the hit way out of rdata itself
   modport ctrl  (output rd_req, output wr_req, output addr, output wdata, input rdata);
   modport store (input rd_req, input wr_req, input addr, input wdata, output rdata);

endinterface

`default_nettype wire

// ==== verilog/icache_ctrl.sv ====
// Main cache FSM covering bypass, full and per-set flush, lookup and refill
// Refill data is expected at least one cycle after refill_gnt_i
`default_nettype none

module icache_ctrl #(
   parameter int NB_WAYS = icache_pkg::NB_WAYS
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        bypass_icache_i,
   output logic                        cache_is_bypassed_o,
   input  logic                        flush_icache_i,
   output logic                        cache_is_flushed_o,
   input  logic                        flush_set_req_i,
   input  icache_pkg::addr_t           flush_set_addr_i,
   output logic                        flush_set_ack_o,
   input  logic                        fetch_req_i,
   input  icache_pkg::addr_t           fetch_addr_i,
   output logic                        fetch_gnt_o,
   output logic                        fetch_rvalid_o,
   output icache_pkg::data_t           fetch_rdata_o,
   output logic                        refill_req_o,
   output icache_pkg::addr_t           refill_addr_o,
   input  logic                        refill_gnt_i,
   input  logic                        refill_r_valid_i,
   input  icache_pkg::data_t           refill_r_data_i,
   output logic                        idle_o,
   tag_bus_if.ctrl                     tag,
   data_bus_if.ctrl                    data,
   input  logic                        hit_i,
   input  logic [$clog2(NB_WAYS)-1:0]  hit_way_i,
   input  logic [NB_WAYS-1:0]          victim_way_i,   // One-hot
   output logic                        victim_take_o
);
   import icache_pkg::*;

   ctrl_state_t         state_q, state_d;
   addr_t               fetch_addr_q;
   logic [NB_WAYS-1:0]  refill_way_q;
   set_idx_t            flush_cnt_q, flush_cnt_d;
   logic                mode_req;

   assign mode_req      = bypass_icache_i | flush_icache_i | flush_set_req_i;
   assign refill_addr_o = {fetch_addr_q[ADDR_W-1:OFFSET_W], OFFSET_W'(0)};   // Line aligned
   assign idle_o        = (state_q == IDLE);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q      <= DISABLED;
         flush_cnt_q  <= '0;
         refill_way_q <= '0;
      end
      else
      begin
         state_q     <= state_d;
         flush_cnt_q <= flush_cnt_d;
         if (victim_take_o)
            refill_way_q <= victim_way_i;
      end
   end

   always_ff @(posedge clk)
   begin
      if (fetch_req_i && fetch_gnt_o)
         fetch_addr_q <= fetch_addr_i;
   end

   ////////////////////
   // Next state and store control
   ////////////////////
   always_comb
   begin
      state_d             = state_q;
      flush_cnt_d         = flush_cnt_q;
      fetch_gnt_o         = 1'b0;
      fetch_rvalid_o      = 1'b0;
      fetch_rdata_o       = refill_r_data_i;
      refill_req_o        = 1'b0;
      victim_take_o       = 1'b0;
      cache_is_bypassed_o = 1'b0;
      cache_is_flushed_o  = 1'b0;
      flush_set_ack_o     = 1'b0;
      tag.rd_req          = 1'b0;
      tag.wr_req          = '0;
      tag.addr            = set_of(fetch_addr_i);   // Lookup reads use the incoming address
      tag.wdata           = {1'b1, tag_of(fetch_addr_q)};
      data.rd_req         = 1'b0;
      data.wr_req         = '0;
      data.addr           = set_of(fetch_addr_i);
      data.wdata          = refill_r_data_i;

      case (state_q)
         DISABLED:
         begin
            cache_is_bypassed_o = 1'b1;
            if (bypass_icache_i)
            begin
               fetch_gnt_o = fetch_req_i;
               if (fetch_req_i)
                  state_d = BYPASS_REFILL;
            end
            else
               state_d = FLUSH_ALL;   // Enabling always starts from a clean cache
         end
         BYPASS_REFILL:
         begin
            cache_is_bypassed_o = 1'b1;
            refill_req_o        = 1'b1;
            if (refill_gnt_i)
               state_d = BYPASS_WAIT_DONE;
         end
         BYPASS_WAIT_DONE:
         begin
            cache_is_bypassed_o = 1'b1;
            fetch_rvalid_o      = refill_r_valid_i;   // Passed through and never stored
            if (refill_r_valid_i)
               state_d = DISABLED;
         end
         FLUSH_ALL:
         begin
            tag.wr_req  = '1;
            tag.addr    = flush_cnt_q;
            tag.wdata   = '0;
            flush_cnt_d = flush_cnt_q + 1'b1;   // Wraps back to 0 after the last set
            if (&flush_cnt_q)
            begin
               cache_is_flushed_o = 1'b1;
               state_d            = IDLE;
            end
         end
         FLUSH_SET:
         begin
            tag.wr_req      = '1;
            tag.addr        = set_of(flush_set_addr_i);
            tag.wdata       = '0;
            flush_set_ack_o = 1'b1;
            state_d         = IDLE;
         end
         IDLE:
         begin
            if (bypass_icache_i)
               state_d = DISABLED;
            else if (flush_icache_i)
               state_d = FLUSH_ALL;
            else if (flush_set_req_i)
               state_d = FLUSH_SET;
            else if (fetch_req_i)
            begin
               fetch_gnt_o = 1'b1;
               tag.rd_req  = 1'b1;
               data.rd_req = 1'b1;
               state_d     = TAG_LOOKUP;
            end
         end
         TAG_LOOKUP:
         begin
            if (hit_i)
            begin
               fetch_rvalid_o = 1'b1;
               fetch_rdata_o  = data.rdata[hit_way_i];
               // Stream the next request unless a mode change is pending
               fetch_gnt_o    = fetch_req_i & ~mode_req;
               tag.rd_req     = fetch_gnt_o;
               data.rd_req    = fetch_gnt_o;
               state_d        = fetch_gnt_o ? TAG_LOOKUP : IDLE;
            end
            else
            begin
               refill_req_o  = 1'b1;
               victim_take_o = 1'b1;
               state_d       = refill_gnt_i ? WAIT_REFILL_DONE : WAIT_REFILL_GNT;
            end
         end
         WAIT_REFILL_GNT:
         begin
            refill_req_o = 1'b1;
            if (refill_gnt_i)
               state_d = WAIT_REFILL_DONE;
         end
         WAIT_REFILL_DONE:
         begin
            fetch_rvalid_o = refill_r_valid_i;
            // Tag and data written in the same cycle the core sees the word
            tag.wr_req     = refill_way_q & {NB_WAYS{refill_r_valid_i}};
            tag.addr       = set_of(fetch_addr_q);
            data.wr_req    = refill_way_q & {NB_WAYS{refill_r_valid_i}};
            data.addr      = set_of(fetch_addr_q);
            if (refill_r_valid_i)
               state_d = IDLE;
         end
         default:
            state_d = DISABLED;
      endcase
   end

   // No new fetch is taken while a refill request is outstanding
   a_no_gnt_in_refill: assert property (@(posedge clk) disable iff (!rst_n)
      refill_req_o |-> !fetch_gnt_o);

   a_refill_way_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      (state_q inside {WAIT_REFILL_GNT, WAIT_REFILL_DONE}) |-> $onehot(refill_way_q));

endmodule

`default_nettype wire

// ==== verilog/icache_way_select.sv ====
// Tag compare and victim choice, combinational on the tag store read data
// The random choice comes from a 4-bit LFSR, so at most 16 ways
`default_nettype none

module icache_way_select #(
   parameter int NB_WAYS = icache_pkg::NB_WAYS
) (
   input  logic                        clk,
   input  logic                        rst_n,
   tag_bus_if.lookup                   tag,
   input  icache_pkg::tag_t            lookup_tag_i,
   output logic                        hit_o,
   output logic [$clog2(NB_WAYS)-1:0]  hit_way_o,
   output logic [NB_WAYS-1:0]          victim_way_o,
   input  logic                        victim_take_i
);
   import icache_pkg::*;

   localparam int WAY_IDX_W = $clog2(NB_WAYS);

   logic [NB_WAYS-1:0]    way_valid;
   logic [NB_WAYS-1:0]    way_match;
   logic [WAY_IDX_W-1:0]  free_way;
   logic                  all_valid;
   logic [3:0]            lfsr_q;   // x^4 + x^3 + 1, never zero

   for (genvar w = 0; w < NB_WAYS; w++)
   begin : g_way
      assign way_valid[w] = tag.rdata[w][TAG_W];
      assign way_match[w] = way_valid[w] & (tag.rdata[w][TAG_W-1:0] == lookup_tag_i);
   end

   // Walk down so the lowest-numbered way wins
   always_comb
   begin
      hit_way_o = '0;
      free_way  = '0;
      for (int w = NB_WAYS - 1; w >= 0; w--)
      begin
         if (way_match[w])
            hit_way_o = WAY_IDX_W'(w);
         if (!way_valid[w])
            free_way = WAY_IDX_W'(w);
      end
   end

   assign hit_o        = |way_match;
   assign all_valid    = &way_valid;
   assign victim_way_o = all_valid ? (NB_WAYS'(1) << lfsr_q[WAY_IDX_W-1:0])
                                   : (NB_WAYS'(1) << free_way);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         lfsr_q <= 4'b0001;
      else if (victim_take_i && all_valid)   // Step only when a valid line is evicted
         lfsr_q <= {lfsr_q[2:0], lfsr_q[3] ^ lfsr_q[2]};
   end

   // Refills only follow a miss, so a set never holds the same tag twice
   a_single_match: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(way_match));

endmodule

`default_nettype wire

// ==== verilog/icache_tag_store.sv ====
// Valid+tag array, one entry per way and set, registered read of all ways
// Every entry comes out of reset invalid
`default_nettype none

module icache_tag_store #(
   parameter int NB_WAYS = icache_pkg::NB_WAYS
) (
   input  logic            clk,
   input  logic            rst_n,
   tag_bus_if.store        tag
);
   import icache_pkg::*;

   tag_entry_t mem_q [NB_WAYS][NB_SETS];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int w = 0; w < NB_WAYS; w++)
         begin
            for (int s = 0; s < NB_SETS; s++)
               mem_q[w][s] <= '0;
         end
         tag.rdata <= '0;
      end
      else
      begin
         for (int w = 0; w < NB_WAYS; w++)
         begin
            if (tag.wr_req[w])
               mem_q[w][tag.addr] <= tag.wdata;   // Whole entry replaced
            if (tag.rd_req)
               tag.rdata[w] <= mem_q[w][tag.addr];
         end
      end
   end

endmodule

`default_nettype wire

// ==== verilog/icache_data_store.sv ====
// Line data array, one 128-bit word per way and set
// Registered read of all ways; contents are undefined until refilled
`default_nettype none

module icache_data_store #(
   parameter int NB_WAYS = icache_pkg::NB_WAYS
) (
   input  logic            clk,
   data_bus_if.store       data
);
   import icache_pkg::*;

   data_t mem_q [NB_WAYS][NB_SETS];

   ////////////////////
   // Per-way write, shared read
   ////////////////////
   always_ff @(posedge clk)
   begin
      for (int w = 0; w < NB_WAYS; w++)
      begin
         if (data.wr_req[w])
            mem_q[w][data.addr] <= data.wdata;
         if (data.rd_req)
            data.rdata[w] <= mem_q[w][data.addr];   // Hit way picked one cycle later
      end
   end

endmodule

`default_nettype wire

// ==== verilog/icache_top.sv ====
// Private instruction cache, 128-bit fetch port, single-beat refill port
// Refill r_valid must come at least one cycle after refill_gnt_i
`default_nettype none

module icache_top #(
   parameter int NB_WAYS = icache_pkg::NB_WAYS
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                bypass_icache_i,
   output logic                cache_is_bypassed_o,
   input  logic                flush_icache_i,
   output logic                cache_is_flushed_o,
   input  logic                flush_set_req_i,
   input  icache_pkg::addr_t   flush_set_addr_i,
   output logic                flush_set_ack_o,
   input  logic                fetch_req_i,
   input  icache_pkg::addr_t   fetch_addr_i,
   output logic                fetch_gnt_o,
   output logic                fetch_rvalid_o,
   output icache_pkg::data_t   fetch_rdata_o,
   output logic                refill_req_o,
   output icache_pkg::addr_t   refill_addr_o,
   input  logic                refill_gnt_i,
   input  logic                refill_r_valid_i,
   input  icache_pkg::data_t   refill_r_data_i,
   output logic                idle_o
);
   import icache_pkg::*;

   logic                        hit;
   logic [$clog2(NB_WAYS)-1:0]  hit_way;
   logic [NB_WAYS-1:0]          victim_way;
   logic                        victim_take;

   tag_bus_if  #(.NB_WAYS(NB_WAYS)) tag_bus ();
   data_bus_if #(.NB_WAYS(NB_WAYS)) data_bus ();

   icache_ctrl #(.NB_WAYS(NB_WAYS)) u_ctrl (
      .tag           (tag_bus),
      .data          (data_bus),
      .hit_i         (hit),
      .hit_way_i     (hit_way),
      .victim_way_i  (victim_way),
      .victim_take_o (victim_take),
      .*
   );

   // Refill address holds the registered fetch address, tag bits intact
   icache_way_select #(.NB_WAYS(NB_WAYS)) u_way_select (
      .clk           (clk),
      .rst_n         (rst_n),
      .tag           (tag_bus),
      .lookup_tag_i  (tag_of(refill_addr_o)),
      .hit_o         (hit),
      .hit_way_o     (hit_way),
      .victim_way_o  (victim_way),
      .victim_take_i (victim_take)
   );

   icache_tag_store  #(.NB_WAYS(NB_WAYS)) u_tag_store  (.clk(clk), .rst_n(rst_n), .tag(tag_bus));
   icache_data_store #(.NB_WAYS(NB_WAYS)) u_data_store (.clk(clk), .data(data_bus));

endmodule

`default_nettype wire

// ==== bench/icache_tb.sv ====
// Reads bench/icache_stimulus.txt relative to the working directory, so run from the root
// Stops at the first mismatch or timeout; unknown refill lines read as zero
`default_nettype none

module icache_tb;
   timeunit 1ns;
   timeprecision 100ps;

   import icache_pkg::*;

   localparam int TIMEOUT = 200;   // Cycles allowed per wait

   logic        clk = 1'b0;
   logic        rst_n = 1'b0;
   logic        bypass_icache_i = 1'b1;   // Leave reset in bypass
   logic        flush_icache_i = 1'b0;
   logic        flush_set_req_i = 1'b0;
   addr_t       flush_set_addr_i = '0;
   logic        fetch_req_i = 1'b0;
   addr_t       fetch_addr_i = '0;
   logic        refill_gnt_i = 1'b0;
   logic        refill_r_valid_i = 1'b0;
   data_t       refill_r_data_i = '0;
   logic        cache_is_bypassed_o;
   logic        cache_is_flushed_o;
   logic        flush_set_ack_o;
   logic        fetch_gnt_o;
   logic        fetch_rvalid_o;
   data_t       fetch_rdata_o;
   logic        refill_req_o;
   addr_t       refill_addr_o;
   logic        idle_o;

   data_t       mem_words [addr_t];   // Line address to word
   addr_t       issue_q [$];
   addr_t       expect_addr_q [$];
   byte         expect_kind_q [$];
   int unsigned refill_count = 0;
   addr_t       last_refill_addr = '0;
   logic        bypass_on = 1'b1;
   int          seed = 30;
   int unsigned mm_delay = 0;
   logic        mm_granted = 1'b0;
   addr_t       mm_addr = '0;

   icache_top #(.NB_WAYS(NB_WAYS)) u_dut (.*);

   always #5 clk = ~clk;

   function automatic addr_t line_of(input addr_t a);
      return {a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
   endfunction

   function automatic data_t mem_word(input addr_t a);
      if (mem_words.exists(a))
         return mem_words[a];
      return '0;
   endfunction

   function automatic int unsigned pick_delay();
      return {$random(seed)} % 4;
   endfunction

   function automatic logic probe(input string name);
      case (name)
         "fetch_gnt_o":         return fetch_gnt_o;
         "fetch_rvalid_o":      return fetch_rvalid_o;
         "cache_is_flushed_o":  return cache_is_flushed_o;
         "cache_is_bypassed_o": return cache_is_bypassed_o;
         "flush_set_ack_o":     return flush_set_ack_o;
         "idle_o":              return idle_o;
         default:               return 1'b0;
      endcase
   endfunction

   ////////////////////
   // Refill memory model
   ////////////////////
   always @(posedge clk)
   begin
      if (refill_r_valid_i)
         refill_r_valid_i <= 1'b0;   // Single beat
      else if (refill_gnt_i)
      begin
         refill_gnt_i <= 1'b0;
         mm_granted    = 1'b1;
         mm_delay      = pick_delay();
      end
      else if (mm_granted)
      begin
         if (mm_delay != 0)
            mm_delay--;
         else
         begin
            refill_r_valid_i <= 1'b1;
            refill_r_data_i  <= mem_word(mm_addr);
            mm_granted        = 1'b0;
            mm_delay          = pick_delay();   // Next grant delay
         end
      end
      else if (refill_req_o)
      begin
         if (mm_delay != 0)
            mm_delay--;
         else
         begin
            refill_gnt_i <= 1'b1;
            mm_addr       = refill_addr_o;
         end
      end
   end

   // Refill handshakes at the port tell a miss from a hit
   always @(posedge clk)
   begin
      if (refill_req_o && refill_gnt_i)
      begin
         refill_count++;
         last_refill_addr = refill_addr_o;
      end
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Some tests failed");
      $fatal(1, "Run stopped at the first failure");
   endtask

   task automatic check_value(input string name, input data_t got, input data_t exp);
      if (got !== exp)
         abort_run($sformatf("ERROR t=%0t %s got %h expected %h", $time, name, got, exp));
   endtask

   task automatic wait_for(input string name);
      int cycles;
      cycles = 0;
      @(posedge clk);
      while (!probe(name))
      begin
         cycles++;
         if (cycles >= TIMEOUT)
            abort_run($sformatf("Timeout, %s stayed low for %0d cycles", name, TIMEOUT));
         @(posedge clk);
      end
   endtask

   ////////////////////
   // Fetch traffic
   ////////////////////
   task automatic issue_reads;
      while (issue_q.size() != 0)
      begin
         fetch_req_i  <= 1'b1;   // Held until granted
         fetch_addr_i <= issue_q[0];
         wait_for("fetch_gnt_o");
         void'(issue_q.pop_front());
      end
      fetch_req_i <= 1'b0;
   endtask

   task automatic collect_reads;
      addr_t       a;
      byte         kind;
      int unsigned refills;
      int unsigned seen;
      seen = refill_count;
      while (expect_addr_q.size() != 0)
      begin
         wait_for("fetch_rvalid_o");
         a       = expect_addr_q.pop_front();
         kind    = expect_kind_q.pop_front();
         refills = refill_count - seen;   // Refills since the previous word
         seen    = refill_count;
         check_value("fetch_rdata_o", fetch_rdata_o, mem_word(line_of(a)));
         if (kind == "H" || kind == "M")
            check_value("refill_req_o count", data_t'(refills), data_t'(kind == "M"));
         if (refills != 0)
            check_value("refill_addr_o", data_t'(last_refill_addr), data_t'(line_of(a)));
         if (bypass_on)
            check_value("cache_is_bypassed_o", data_t'(cache_is_bypassed_o), data_t'(1'b1));
      end
   endtask

   // Requests stream while their words come back in order
   task automatic run_reads;
      fork
         issue_reads();
         collect_reads();
      join
   endtask

   task automatic set_bypass(input logic bypass);
      bypass_icache_i <= bypass;
      bypass_on        = bypass;
      if (bypass)
         wait_for("cache_is_bypassed_o");
      else
      begin
         wait_for("cache_is_flushed_o");
         wait_for("idle_o");
      end
   endtask

   task automatic flush_all;
      flush_icache_i <= 1'b1;
      @(posedge clk);
      flush_icache_i <= 1'b0;
      wait_for("cache_is_flushed_o");
      wait_for("idle_o");
   endtask

   task automatic flush_set(input addr_t a);
      flush_set_req_i  <= 1'b1;
      flush_set_addr_i <= a;
      wait_for("flush_set_ack_o");
      flush_set_req_i  <= 1'b0;
   endtask

   initial
   begin : main
      int    fd;
      int    n;
      int    needed;
      string line;
      byte   cmd;
      addr_t a;
      data_t d;
      fd = $fopen("bench/icache_stimulus.txt", "r");
      if (fd == 0)
         abort_run("Cannot open bench/icache_stimulus.txt");
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      while ($fgets(line, fd) != 0)
      begin
         cmd    = line.getc(0);
         n      = 0;
         needed = 0;
         case (cmd)
            "W":
            begin
               needed = 2;
               n      = $sscanf(line.substr(2, line.len() - 1), "%h %h", a, d);
            end
            "R":
            begin
               needed = 1;
               n      = $sscanf(line.substr(4, line.len() - 1), "%h", a);
            end
            "B", "S":
            begin
               needed = 1;
               n      = $sscanf(line.substr(2, line.len() - 1), "%h", a);
            end
            default: ;
         endcase
         if (n < needed)
            abort_run({"Malformed stimulus line: ", line});
         case (cmd)
            "#", "\n", "\r": ;   // Comment or blank line
            "W": mem_words[line_of(a)] = d;
            "R":
            begin
               issue_q.push_back(a);
               expect_addr_q.push_back(a);
               expect_kind_q.push_back(line.getc(2));
            end
            "B":
            begin
               run_reads();
               set_bypass(a != 0);
            end
            "F":
            begin
               run_reads();
               flush_all();
            end
            "S":
            begin
               run_reads();
               flush_set(a);
            end
            default: abort_run({"Unknown stimulus command: ", line});
         endcase
      end
      run_reads();
      $fclose(fd);
      $display("All tests passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== icache.f ====
verilog/icache_pkg.sv
verilog/icache_if.sv
verilog/icache_ctrl.sv
verilog/icache_way_select.sv
verilog/icache_tag_store.sv
verilog/icache_data_store.sv
verilog/icache_top.sv
bench/icache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the cache testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module icache_tb -f icache.f -o icache_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit $status
fi

./obj_dir/icache_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit $status
fi

exit 0

// ==== bench/icache_stimulus.txt ====
# W addr word: refill memory line | R kind addr: read, kind H hit, M miss, X either
# B 0/1: bypass off/on | F: flush all | S addr: flush the set holding addr
W 00001000 00112233445566778899aabbccddeeff
W 00001010 0f1e2d3c4b5a69788796a5b4c3d2e1f0
W 00002020 20202020aaaa0000bbbb1111cccc2222
W 00002120 21212121aaaa0001bbbb1112cccc2223
W 00002220 22222222aaaa0002bbbb1113cccc2224
W 00002320 23232323aaaa0003bbbb1114cccc2225
W 00002420 24242424aaaa0004bbbb1115cccc2226
B 1
R M 00001000
R M 00001010
R M 00001000
B 0
R M 00001000
R M 00001010
R H 00001000
R H 00001010
R H 00001008
R M 00002020
R M 00002120
R M 00002220
R M 00002320
R M 00002420
R H 00002420
R X 00002020
S 00000020
R M 00002420
R H 00001000
F
R M 00001000
R M 00001010
R M 00005550
